// File: icache.f
rtl/icache_pkg.sv
rtl/way_store.sv
rtl/lru_ages.sv
rtl/line_fill.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tb/tb_mem.sv
tb/icache_tb.sv

// File: rtl/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl import icache_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               req,
  input  addr_t              addr,
  input  lookup_t [WAYS-1:0] rd_ways,
  input  way_t               victim,
  input  logic               fill_done,
  input  word_t              crit_word,
  output set_t               rd_set,
  output logic               touch,
  output way_t               touch_way,
  output logic               fill_start,
  output addr_t              fill_addr,
  output way_t               fill_way,
  output word_t              ins,
  output logic               ok,
  output logic               miss
);

  ctrl_state_t     state;
  ctrl_state_t     state_d;
  addr_t           req_addr;
  logic [WAYS-1:0] hit_vec;
  logic            hit;
  way_t            hit_way;
  word_t           hit_word;

  ////////////////////////////////////////////////////////////////////////////
  // Tag compare

  always_comb
  begin
    hit_way = '0;
    for (int w = WAYS - 1; w >= 0; w--)
    begin
      hit_vec[w] = rd_ways[w].valid && (rd_ways[w].tag == addr_tag(req_addr));
      if (hit_vec[w])
        hit_way = way_t'(w);
    end
  end

  assign hit      = |hit_vec;
  assign hit_word = rd_ways[hit_way].data[addr_offs(req_addr)];

  // Array read follows the CPU address while idle
  assign rd_set    = (state == IDLE) ? addr_set(addr) : addr_set(req_addr);
  assign touch     = ((state == LOOKUP) && hit) || ((state == FILL) && fill_done);
  assign touch_way = (state == LOOKUP) ? hit_way : fill_way;
  assign fill_addr = req_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Request FSM

  always_comb
  begin
    state_d = state;
    case (state)
      IDLE:    if (req) state_d = LOOKUP;
      LOOKUP:  state_d = hit ? RESPOND : FILL;
      FILL:    if (fill_done) state_d = RESPOND;
      RESPOND: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state      <= IDLE;
      fill_start <= 1'b0;
      ok         <= 1'b0;
      miss       <= 1'b0;
    end
    else
    begin
      state      <= state_d;
      fill_start <= (state == LOOKUP) && !hit;
      ok         <= (state == RESPOND);
      // Held through the ok pulse of the refilled request
      if (fill_start)
        miss <= 1'b1;
      else if (ok)
        miss <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == IDLE) && req)
      req_addr <= addr;
    if (state == LOOKUP)
    begin
      if (hit)
        ins <= hit_word;
      else
        fill_way <= victim;
    end
    if ((state == FILL) && fill_done)
      ins <= crit_word;
  end

endmodule

// File: rtl/icache_pkg.sv
package icache_pkg;

  localparam int WAYS       = 4;
  localparam int SETS       = 16;
  localparam int LINE_WORDS = 16;
  localparam int TAG_W      = 22;

  typedef logic [31:0]            word_t;
  typedef logic [31:0]            addr_t;
  typedef logic [TAG_W-1:0]       tag_t;
  typedef logic [3:0]             set_t;
  typedef logic [3:0]             offs_t;
  typedef logic [1:0]             way_t;
  typedef logic [1:0]             age_t;
  typedef word_t [LINE_WORDS-1:0] line_t;

  // One complete line write into the arrays
  typedef struct packed {
    logic  we;
    way_t  way;
    set_t  set;
    tag_t  tag;
    line_t data;
  } fill_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    line_t data;
  } lookup_t;

  typedef enum logic [1:0] {IDLE, LOOKUP, FILL, RESPOND} ctrl_state_t;

  // Address fields
  function automatic tag_t addr_tag(addr_t a);
    return a[31:32-TAG_W];
  endfunction

  function automatic set_t addr_set(addr_t a);
    return a[9:6];
  endfunction

  function automatic offs_t addr_offs(addr_t a);
    return a[5:2];
  endfunction

endpackage

// File: rtl/icache_top.sv
`timescale 1ns/100ps

module icache_top import icache_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  req,
  input  addr_t addr,
  input  logic  mem_valid,
  input  word_t mem_data,
  output word_t ins,
  output logic  ok,
  output logic  miss,
  output logic  mem_req,
  output addr_t mem_addr
);

  set_t               rd_set;
  lookup_t [WAYS-1:0] rd_ways;
  way_t               victim;
  logic               touch;
  way_t               touch_way;
  logic               fill_start;
  addr_t              fill_addr;
  way_t               fill_way;
  fill_t              fill;
  logic               fill_done;
  word_t              crit_word;

  icache_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .addr       (addr),
    .rd_ways    (rd_ways),
    .victim     (victim),
    .fill_done  (fill_done),
    .crit_word  (crit_word),
    .rd_set     (rd_set),
    .touch      (touch),
    .touch_way  (touch_way),
    .fill_start (fill_start),
    .fill_addr  (fill_addr),
    .fill_way   (fill_way),
    .ins        (ins),
    .ok         (ok),
    .miss       (miss)
  );

  way_store u_ways (
    .clk     (clk),
    .rst     (rst),
    .rd_set  (rd_set),
    .fill    (fill),
    .rd_ways (rd_ways)
  );

  lru_ages u_ages (
    .clk        (clk),
    .rst        (rst),
    .rd_set     (rd_set),
    .valid_ways ({rd_ways[3].valid, rd_ways[2].valid, rd_ways[1].valid, rd_ways[0].valid}),
    .touch      (touch),
    .touch_way  (touch_way),
    .victim     (victim)
  );

  line_fill u_fill (
    .clk        (clk),
    .rst        (rst),
    .fill_start (fill_start),
    .fill_addr  (fill_addr),
    .fill_way   (fill_way),
    .mem_valid  (mem_valid),
    .mem_data   (mem_data),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .fill       (fill),
    .fill_done  (fill_done),
    .crit_word  (crit_word)
  );

endmodule

// File: rtl/line_fill.sv
`timescale 1ns/100ps

module line_fill import icache_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  fill_start,
  input  addr_t fill_addr,
  input  way_t  fill_way,
  input  logic  mem_valid,
  input  word_t mem_data,
  output logic  mem_req,
  output addr_t mem_addr,
  output fill_t fill,
  output logic  fill_done,
  output word_t crit_word
);

  offs_t beat;
  offs_t slot;
  way_t  way_q;
  line_t line_buf;
  logic  take;

  assign take = mem_req && mem_valid;

  // Wrapping position of the current beat within the line
  assign slot = addr_offs(mem_addr) + beat;

  ////////////////////////////////////////////////////////////////////////////
  // Burst control

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      mem_req   <= 1'b0;
      beat      <= '0;
      fill_done <= 1'b0;
    end
    else
    begin
      fill_done <= 1'b0;
      if (fill_start)
      begin
        mem_req <= 1'b1;
        beat    <= '0;
      end
      else if (take)
      begin
        beat <= beat + 1'b1;
        if (beat == offs_t'(LINE_WORDS - 1))
        begin
          mem_req   <= 1'b0;
          fill_done <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Line buffer

  always_ff @(posedge clk)
  begin
    if (fill_start)
    begin
      mem_addr <= {fill_addr[31:2], 2'b00};
      way_q    <= fill_way;
    end
    if (take)
    begin
      line_buf[slot] <= mem_data;
      if (beat == '0)
        crit_word <= mem_data;
    end
  end

  assign fill = '{
    we:   fill_done,
    way:  way_q,
    set:  addr_set(mem_addr),
    tag:  addr_tag(mem_addr),
    data: line_buf
  };

endmodule

// File: rtl/lru_ages.sv
`timescale 1ns/100ps

module lru_ages import icache_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  set_t            rd_set,
  input  logic [WAYS-1:0] valid_ways,
  input  logic            touch,
  input  way_t            touch_way,
  output way_t            victim
);

  age_t [WAYS-1:0] ages [SETS];
  age_t [WAYS-1:0] rd_ages;
  age_t [WAYS-1:0] new_ages;
  set_t            set_q;
  age_t            oldest;
  logic            found;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < SETS; s++)
        ages[s] <= '0;
      rd_ages <= '0;
      set_q   <= '0;
    end
    else
    begin
      if (touch)
        ages[set_q] <= new_ages;
      rd_ages <= ages[rd_set];
      set_q   <= rd_set;
    end
  end

  // Ways no older than the touched one age by one, saturating
  always_comb
  begin
    for (int w = 0; w < WAYS; w++)
    begin
      if (way_t'(w) == touch_way)
        new_ages[w] = '0;
      else if ((rd_ages[w] <= rd_ages[touch_way]) && !(&rd_ages[w]))
        new_ages[w] = rd_ages[w] + 1'b1;
      else
        new_ages[w] = rd_ages[w];
    end
  end

  // Lowest invalid way first, else lowest way of the highest age
  always_comb
  begin
    victim = '0;
    oldest = rd_ages[0];
    found  = 1'b0;
    for (int w = WAYS - 1; w >= 0; w--)
    begin
      if (!valid_ways[w])
      begin
        victim = way_t'(w);
        found  = 1'b1;
      end
    end
    if (!found)
    begin
      for (int w = 1; w < WAYS; w++)
      begin
        if (rd_ages[w] > oldest)
        begin
          victim = way_t'(w);
          oldest = rd_ages[w];
        end
      end
    end
  end

endmodule

// File: rtl/way_store.sv
`timescale 1ns/100ps

module way_store import icache_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  set_t               rd_set,
  input  fill_t              fill,
  output lookup_t [WAYS-1:0] rd_ways
);

  tag_t                       tag_mem  [WAYS][SETS];
  line_t                      line_mem [WAYS][SETS];
  logic [WAYS-1:0][SETS-1:0]  valid;
  tag_t                       rd_tag   [WAYS];
  line_t                      rd_line  [WAYS];
  logic [WAYS-1:0]            rd_valid;

  // Tag and data arrays
  always_ff @(posedge clk)
  begin
    if (fill.we)
    begin
      tag_mem[fill.way][fill.set]  <= fill.tag;
      line_mem[fill.way][fill.set] <= fill.data;
    end
    for (int w = 0; w < WAYS; w++)
    begin
      rd_tag[w]  <= tag_mem[w][rd_set];
      rd_line[w] <= line_mem[w][rd_set];
    end
  end

  // Valid bits
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid    <= '0;
      rd_valid <= '0;
    end
    else
    begin
      if (fill.we)
        valid[fill.way][fill.set] <= 1'b1;
      for (int w = 0; w < WAYS; w++)
        rd_valid[w] <= valid[w][rd_set];
    end
  end

  always_comb
  begin
    for (int w = 0; w < WAYS; w++)
      rd_ways[w] = '{valid: rd_valid[w], tag: rd_tag[w], data: rd_line[w]};
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module icache_tb -f icache.f -o icache_sim

# The simulation stops with a non-zero status on failure, the log decides
./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

// File: tb/icache_tb.sv
`timescale 1ns/100ps

module icache_tb import icache_pkg::*; ();

  localparam int N_RAND      = 400;
  localparam int N_DIR       = 40;
  localparam int MAX_GAP     = 3;
  localparam int CYCLE_LIMIT = (N_RAND + N_DIR) * (LINE_WORDS * (MAX_GAP + 1) + 8) + 16;

  logic  clk;
  logic  rst;
  logic  req;
  addr_t addr;
  logic  mem_valid;
  word_t mem_data;
  word_t ins;
  logic  ok;
  logic  miss;
  logic  mem_req;
  addr_t mem_addr;
  int    bursts;
  logic  order_err;
  int    cycles;
  integer seed;

  // Reference model state
  tag_t  m_tag   [WAYS][SETS];
  logic  m_valid [WAYS][SETS];
  age_t  m_age   [SETS][WAYS];
  addr_t line5   [5];

  icache_top uut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .addr      (addr),
    .mem_valid (mem_valid),
    .mem_data  (mem_data),
    .ins       (ins),
    .ok        (ok),
    .miss      (miss),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr)
  );

  tb_mem u_mem (
    .clk       (clk),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_valid (mem_valid),
    .mem_data  (mem_data),
    .bursts    (bursts),
    .order_err (order_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles without finishing the tests", cycles);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  always @(posedge order_err)
  begin
    $display("TEST FAILED");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  function automatic word_t mem_word(addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  // Returns 1 on a predicted miss and updates tags, valid bits and ages
  function automatic bit model_access(addr_t a);
    set_t s;
    tag_t t;
    int   way;
    bit   hit;
    age_t ref_age;
    s   = a[9:6];
    t   = a[31:10];
    hit = 1'b0;
    way = -1;
    for (int w = 0; w < WAYS; w++)
    begin
      if (m_valid[w][s] && (m_tag[w][s] == t))
      begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit)
    begin
      for (int w = WAYS - 1; w >= 0; w--)
        if (!m_valid[w][s])
          way = w;
      if (way < 0)
      begin
        way = 0;
        for (int w = 1; w < WAYS; w++)
          if (m_age[s][w] > m_age[s][way])
            way = w;
      end
      m_valid[way][s] = 1'b1;
      m_tag[way][s]   = t;
    end
    ref_age = m_age[s][way];
    for (int w = 0; w < WAYS; w++)
    begin
      if (w == way)
        m_age[s][w] = '0;
      else if ((m_age[s][w] <= ref_age) && (m_age[s][w] != 2'd3))
        m_age[s][w] = m_age[s][w] + 2'd1;
    end
    return !hit;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks and CPU requests

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // expect_miss below zero leaves the outcome to the model alone
  task automatic fetch(input addr_t a, input int expect_miss);
    bit pred;
    int cyc;
    int bursts_before;
    bit saw_miss;
    bit saw_mem;
    pred = model_access(a);
    if (expect_miss >= 0)
      check_eq(32'(pred), expect_miss, "model prediction");
    @(negedge clk);
    bursts_before = bursts;
    req      = 1'b1;
    addr     = a;
    cyc      = 0;
    saw_miss = 1'b0;
    saw_mem  = 1'b0;
    do
    begin
      @(negedge clk);
      cyc = cyc + 1;
      if (miss)
        saw_miss = 1'b1;
      if (mem_req)
      begin
        saw_mem = 1'b1;
        check_eq(mem_addr, {a[31:2], 2'b00}, "mem_addr");
      end
    end
    while (!ok);
    req = 1'b0;
    check_eq(ins, mem_word(a), "ins");
    check_eq(32'(miss), 32'(pred), "miss during ok");
    check_eq(32'(saw_miss), 32'(pred), "miss seen");
    check_eq(32'(saw_mem), 32'(pred), "mem_req seen");
    check_eq(bursts - bursts_before, 32'(pred), "burst count");
    if (!pred)
      check_eq(cyc, 3, "hit latency");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  initial
  begin
    seed   = 32'h4e2f;
    cycles = 0;
    rst    = 1'b1;
    req    = 1'b0;
    addr   = '0;
    for (int w = 0; w < WAYS; w++)
      for (int s = 0; s < SETS; s++)
      begin
        m_valid[w][s] = 1'b0;
        m_tag[w][s]   = '0;
        m_age[s][w]   = '0;
      end
    for (int k = 0; k < 5; k++)
      line5[k] = addr_t'(32'h0002_0000 + k * 1024 + 5 * 64 + k * 4);
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Cold miss, then hits in the same line
    fetch(32'h0000_0128, 1);
    fetch(32'h0000_0128, 0);
    fetch(32'h0000_0100, 0);
    fetch(32'h0000_0114, 0);
    fetch(32'h0000_013c, 0);

    // Critical word at every offset, one set each
    for (int i = 0; i < LINE_WORDS; i++)
      fetch(addr_t'(32'h0001_0000 + i * 64 + i * 4), 1);

    // Four lines in set 5
    for (int k = 0; k < 4; k++)
      fetch(line5[k], 1);
    for (int k = 0; k < 4; k++)
      fetch(line5[k], 0);

    // Order B A D C leaves B oldest
    fetch(line5[1], 0);
    fetch(line5[0], 0);
    fetch(line5[3], 0);
    fetch(line5[2], 0);
    fetch(line5[4], 1);
    fetch(line5[0], 0);
    fetch(line5[2], 0);
    fetch(line5[3], 0);
    fetch(line5[1], 1);

    // Random traffic over 8 tags and 2 sets
    for (int n = 0; n < N_RAND; n++)
      fetch(addr_t'($random(seed)) & 32'h0000_1c7c, -1);

    $display("TEST OK");
    $finish;
  end

endmodule

// File: tb/tb_mem.sv
`timescale 1ns/100ps

module tb_mem import icache_pkg::*; (
  input  logic  clk,
  input  logic  mem_req,
  input  addr_t mem_addr,
  output logic  mem_valid,
  output word_t mem_data,
  output int    bursts,
  output logic  order_err
);

  integer seed;
  addr_t  base;
  offs_t  offs;
  int     gap;

  // Answers each refill with a wrapping burst, driven on the falling edge
  initial
  begin
    seed      = 32'h4e2f;
    mem_valid = 1'b0;
    mem_data  = '0;
    bursts    = 0;
    order_err = 1'b0;
    forever
    begin
      @(negedge clk);
      if (mem_req)
      begin
        base = mem_addr;
        for (int k = 0; k < LINE_WORDS; k++)
        begin
          // Up to three idle cycles before each beat
          gap = $unsigned($random(seed)) % 4;
          repeat (gap) @(negedge clk);
          if (!mem_req || (mem_addr != base))
          begin
            $display("Memory saw the refill request dropped or moved before beat %0d", k);
            order_err = 1'b1;
          end
          offs      = addr_offs(base) + offs_t'(k);
          mem_valid = 1'b1;
          mem_data  = {base[31:6], offs, 2'b00} ^ 32'h5a5a_0000;
          @(negedge clk);
          mem_valid = 1'b0;
        end
        if (mem_req)
        begin
          $display("Memory saw the refill request still high after %0d beats", LINE_WORDS);
          order_err = 1'b1;
        end
        bursts = bursts + 1;
      end
    end
  end

endmodule
